// File: src.f
+incdir+common
common/codec_cfg_pkg.sv
common/codec_pcm_pkg.sv
common/codec_ifs.sv
source/codec_regs.sv
source/frame_timer.sv
codec_serial/dac_serializer.sv
codec_serial/adc_deserializer.sv
source/codec_drvr.sv
testbench/tb_clk_gen.sv
testbench/codec_drvr_asserts.sv
testbench/tb_codec_drvr.sv

// File: Bender.yml
package:
  name: codec_drvr

export_include_dirs:
  - common

sources:
  - files:
      - common/codec_cfg_pkg.sv
      - common/codec_pcm_pkg.sv
      - common/codec_ifs.sv
      - source/codec_regs.sv
      - source/frame_timer.sv
      - codec_serial/dac_serializer.sv
      - codec_serial/adc_deserializer.sv
      - source/codec_drvr.sv
  - target: simulation
    files:
      - testbench/tb_clk_gen.sv
      - testbench/codec_drvr_asserts.sv
      - testbench/tb_codec_drvr.sv

// File: testbench/tb_codec_drvr.sv
// Table-driven testbench: loopback codec model, host agents for both handshakes,
// register, loopback, underrun, overrun and disable tests, watchdog
`timescale 1ns/1ps
`include "codec_params.svh"

module tb_codec_drvr;

  localparam int K_REGS = 0, K_LOOP = 1, K_UNDER = 2, K_OVER = 3, K_OFF = 4;

  typedef struct {
    string       name;
    int          kind;
    int          wl;      // Word length code
    int          div;
    int          fs;
    int          n;       // Pair count or overrun sync count
    logic [31:0] dl[8];
    logic [31:0] dr[8];
    logic [31:0] el[8];   // Expected ADC values
    logic [31:0] er[8];
  } row_t;

  logic        clk, rst_n;
  logic        lb_wr_en, lb_rd_en, lb_wr_valid, lb_rd_valid;
  logic [7:0]  lb_addr;
  logic [31:0] lb_wr_data, lb_rd_data;
  logic        dac_req, dac_ack, adc_req, adc_ack;
  logic [31:0] dac_left, dac_right, adc_left, adc_right;
  logic        aud_adcdat, aud_adclrck, aud_bclk, aud_dacdat, aud_daclrck;

  row_t        tbl[8];
  logic [31:0] dac_ql[$], dac_qr[$], rx_l[$], rx_r[$];
  longint      sync_q[$];
  longint      cyc;
  logic        lrck_prev;
  logic        dac_hold, adc_hold;
  int          errors, wd_cycles;

  tb_clk_gen u_clk (.clk, .rst_n);

  codec_drvr u_dut (
    .clk, .rst_n, .lb_wr_en, .lb_rd_en, .lb_addr, .lb_wr_data,
    .lb_wr_valid, .lb_rd_valid, .lb_rd_data,
    .dac_req, .dac_ack, .dac_left, .dac_right,
    .adc_req, .adc_ack, .adc_left, .adc_right,
    .aud_adcdat, .aud_adclrck, .aud_bclk, .aud_dacdat, .aud_daclrck
  );

  // Codec model loops DAC data back to the ADC
  always @(posedge clk)
    aud_adcdat <= aud_dacdat;

  // DAC host handing out queued pairs
  always @(posedge clk)
  begin
    if (!rst_n)
      dac_ack <= 1'b0;
    else if (dac_ack)
    begin
      if (!dac_req)
        dac_ack <= 1'b0;
    end
    else if (dac_req && !dac_hold && dac_ql.size() > 0)
    begin
      dac_left  <= dac_ql.pop_front();
      dac_right <= dac_qr.pop_front();
      dac_ack   <= 1'b1;
    end
  end

  // ADC host collecting offered pairs
  always @(posedge clk)
  begin
    if (!rst_n)
      adc_ack <= 1'b0;
    else if (adc_ack)
    begin
      if (!adc_req)
        adc_ack <= 1'b0;
    end
    else if (adc_req && !adc_hold)
    begin
      rx_l.push_back(adc_left);
      rx_r.push_back(adc_right);
      adc_ack <= 1'b1;
    end
  end

  always @(posedge clk)
    cyc <= cyc + 1;

  // Sync rise times in clock cycles
  always @(negedge clk)
  begin
    if (aud_daclrck && !lrck_prev)
      sync_q.push_back(cyc);
    lrck_prev <= aud_daclrck;
  end

  initial
  begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk);
    $display("Watchdog expired before the tests finished");
    $display("TESTS FAILED");
    $finish;
  end

  function automatic int wl_bits(input int code);
    case (code)
      0:       return 16;
      1:       return 20;
      2:       return 24;
      default: return 32;
    endcase
  endfunction

  // Top W bits sign-extended to 32
  function automatic logic [31:0] expect_sample(input logic [31:0] v, input int w);
    logic [31:0] t;
    t = v >> (32 - w);
    for (int i = w; i < 32; i++)
      t[i] = t[w-1];
    return t;
  endfunction

  // Table row, sample pairs are filled in later
  function automatic row_t make_row(input string name, input int kind, input int wl,
                                    input int div, input int fs, input int n);
    row_t r;
    r.name = name;
    r.kind = kind;
    r.wl   = wl;
    r.div  = div;
    r.fs   = fs;
    r.n    = n;
    return r;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
    begin
      $display("Mismatch %s: expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
    int n;
    n = 0;
    @(posedge clk);
    lb_wr_en   <= 1'b1;
    lb_addr    <= addr;
    lb_wr_data <= data;
    @(posedge clk);
    lb_wr_en <= 1'b0;
    @(negedge clk);
    while (!lb_wr_valid && n < 4)
    begin
      @(negedge clk);
      n++;
    end
    if (!lb_wr_valid)
    begin
      $display("Local bus write to %h got no lb_wr_valid", addr);
      errors++;
    end
  endtask

  task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
    int n;
    n = 0;
    @(posedge clk);
    lb_rd_en <= 1'b1;
    lb_addr  <= addr;
    @(posedge clk);
    lb_rd_en <= 1'b0;
    @(negedge clk);
    while (!lb_rd_valid && n < 4)
    begin
      @(negedge clk);
      n++;
    end
    data = lb_rd_data;
    if (!lb_rd_valid)
    begin
      $display("Local bus read of %h got no lb_rd_valid", addr);
      errors++;
    end
  endtask

  task automatic wait_pairs(input string name, input int n, input int limit);
    int cnt;
    cnt = 0;
    while (rx_l.size() < n && cnt < limit)
    begin
      @(negedge clk);
      cnt++;
    end
    if (rx_l.size() < n)
    begin
      $display("%s: timed out waiting for ADC pair %0d", name, n);
      errors++;
    end
  endtask

  task automatic wait_idle(input string name, input int limit);
    logic [31:0] d;
    int          cnt;
    cnt = 0;
    bus_read(`CODEC_STATUS_ADDR, d);
    while (d[2:0] != 3'd0 && cnt < limit)
    begin
      bus_read(`CODEC_STATUS_ADDR, d);
      cnt++;
    end
    if (d[2:0] != 3'd0)
    begin
      $display("%s: frame timer did not return to idle", name);
      errors++;
    end
  endtask

  task automatic run_regs(input row_t r);
    logic [31:0] d;
    bus_write(`CODEC_BCLK_DIV_ADDR, 32'h5A);
    bus_read(`CODEC_BCLK_DIV_ADDR, d);
    check({r.name, " bclk_div"}, 32'h5A, d);
    bus_write(`CODEC_FS_VAL_ADDR, 32'h1234);
    bus_read(`CODEC_FS_VAL_ADDR, d);
    check({r.name, " fs_val"}, 32'h1234, d);
    bus_write(`CODEC_CONFIG_ADDR, 32'hC);
    bus_read(`CODEC_CONFIG_ADDR, d);
    check({r.name, " config"}, 32'hC, d);
    bus_read(8'h14, d);
    check({r.name, " unmapped 0x14"}, 32'hDEAD_BABE, d);
    bus_read(8'h40, d);
    check({r.name, " unmapped 0x40"}, 32'hDEAD_BABE, d);
    // 16-bit words need fs_val of at least 32
    bus_write(`CODEC_BCLK_DIV_ADDR, r.div);
    bus_write(`CODEC_FS_VAL_ADDR, r.fs);
    bus_write(`CODEC_CONFIG_ADDR, 32'h3);
    bus_read(`CODEC_CONFIG_ADDR, d);
    check({r.name, " config enables"}, 32'h3, d);
    bus_read(`CODEC_STATUS_ADDR, d);
    check({r.name, " status cfg_err"}, 32'h8, d);
    repeat (100)
    begin
      @(negedge clk);
      if (aud_bclk)
      begin
        $display("%s: bit clock toggled with an invalid configuration", r.name);
        errors++;
        break;
      end
    end
    bus_write(`CODEC_CONFIG_ADDR, 32'h0);
  endtask

  task automatic run_stream(input row_t r);
    logic [31:0] d;
    int          fl, npush, cnt, base;
    fl    = (r.fs + 1) * (r.div + 1);
    npush = (r.kind == K_OVER) ? r.n + 2 : r.n;
    bus_read(`CODEC_XRUN_ADDR, d);   // Clears both counters
    rx_l.delete();
    rx_r.delete();
    sync_q.delete();
    dac_hold = (r.kind == K_UNDER);
    adc_hold = (r.kind == K_OVER);
    bus_write(`CODEC_BCLK_DIV_ADDR, r.div);
    bus_write(`CODEC_FS_VAL_ADDR, r.fs);
    bus_write(`CODEC_CONFIG_ADDR, r.wl << 2);
    if (r.kind == K_LOOP || r.kind == K_OVER)
    begin
      for (int i = 0; i < npush; i++)
      begin
        dac_ql.push_back(r.dl[i]);
        dac_qr.push_back(r.dr[i]);
      end
      cnt = 0;
      do
      begin
        @(negedge clk);
        cnt++;
      end
      while (!(dac_ql.size() == npush - 1 && !dac_req && !dac_ack) && cnt < 20);
      if (dac_req || dac_ack)
      begin
        $display("%s: DAC buffer was not filled before enable", r.name);
        errors++;
      end
    end
    bus_write(`CODEC_CONFIG_ADDR, (r.wl << 2) | 3);
    case (r.kind)
      K_LOOP:
      begin
        wait_pairs(r.name, r.n, (r.n + 2) * fl);
        for (int i = 0; i < r.n && i < rx_l.size(); i++)
        begin
          check($sformatf("%s left %0d", r.name, i), r.el[i], rx_l[i]);
          check($sformatf("%s right %0d", r.name, i), r.er[i], rx_r[i]);
        end
        if (sync_q.size() < 2)
        begin
          $display("%s: fewer than two sync pulses seen", r.name);
          errors++;
        end
        for (int i = 1; i < sync_q.size(); i++)
          check({r.name, " sync spacing"}, fl, sync_q[i] - sync_q[i-1]);
      end
      K_UNDER:
      begin
        wait_pairs(r.name, r.n, (r.n + 2) * fl);
        bus_write(`CODEC_CONFIG_ADDR, (r.wl << 2) | 2);   // DAC off and ADC on
        wait_pairs(r.name, r.n + 1, 2 * fl);
      end
      K_OVER:
      begin
        cnt = 0;
        while (!adc_req && cnt < 3 * fl)
        begin
          @(negedge clk);
          cnt++;
        end
        @(negedge clk);
        base = sync_q.size();
        cnt  = 0;
        while (sync_q.size() < base + r.n && cnt < (r.n + 1) * fl)
        begin
          @(negedge clk);
          cnt++;
        end
        repeat (4) @(negedge clk);
        bus_read(`CODEC_XRUN_ADDR, d);
        check({r.name, " overrun count"}, r.n, d[15:8]);
        check({r.name, " underrun count"}, 0, d[7:0]);
        adc_hold = 1'b0;
        wait_pairs(r.name, 2, 2 * fl);
        if (rx_l.size() >= 2)
        begin
          check({r.name, " pending left"}, r.el[0], rx_l[0]);
          check({r.name, " pending right"}, r.er[0], rx_r[0]);
          check({r.name, " next left"}, r.el[r.n + 1], rx_l[1]);
          check({r.name, " next right"}, r.er[r.n + 1], rx_r[1]);
        end
      end
      default:
      begin
        while (sync_q.size() < 2)
          @(negedge clk);
      end
    endcase
    bus_write(`CODEC_CONFIG_ADDR, r.wl << 2);
    wait_idle(r.name, fl / 2 + 10);
    if (r.kind == K_UNDER)
    begin
      bus_read(`CODEC_XRUN_ADDR, d);
      check({r.name, " underrun count"}, rx_l.size(), d[7:0]);
      foreach (rx_l[i])
        check($sformatf("%s pair %0d", r.name, i), 0, rx_l[i] | rx_r[i]);
      bus_read(`CODEC_XRUN_ADDR, d);
      check({r.name, " underrun after clear"}, 0, d[7:0]);
    end
    if (r.kind == K_OFF)
    begin
      bus_read(`CODEC_STATUS_ADDR, d);
      check({r.name, " status"}, 0, d);
      repeat (fl)
      begin
        @(negedge clk);
        if (aud_bclk || aud_daclrck || aud_adclrck)
        begin
          $display("%s: bit clock or sync active after disable", r.name);
          errors++;
          break;
        end
      end
    end
    dac_hold = 1'b0;
    adc_hold = 1'b0;
  endtask

  initial
  begin
    int fails, err0, frames, wd;
    lb_wr_en   = 1'b0;
    lb_rd_en   = 1'b0;
    lb_addr    = '0;
    lb_wr_data = '0;
    dac_ack    = 1'b0;
    dac_left   = '0;
    dac_right  = '0;
    adc_ack    = 1'b0;
    aud_adcdat = 1'b0;
    dac_hold   = 1'b0;
    adc_hold   = 1'b0;
    lrck_prev  = 1'b0;
    cyc        = 0;
    errors     = 0;
    fails      = 0;
    void'($urandom(32'h31d5_9d12));
    tbl[0] = make_row("regs",     K_REGS,  0, 2, 20, 0);
    tbl[1] = make_row("loop_16",  K_LOOP,  0, 2, 40, 4);
    tbl[2] = make_row("loop_20",  K_LOOP,  1, 3, 45, 4);
    tbl[3] = make_row("loop_24",  K_LOOP,  2, 2, 50, 4);
    tbl[4] = make_row("loop_32",  K_LOOP,  3, 4, 64, 4);
    tbl[5] = make_row("underrun", K_UNDER, 0, 2, 33, 3);
    tbl[6] = make_row("overrun",  K_OVER,  2, 2, 48, 3);
    tbl[7] = make_row("disable",  K_OFF,   0, 3, 32, 0);
    wd = 3000;
    foreach (tbl[t])
    begin
      for (int i = 0; i < 8; i++)
      begin
        tbl[t].dl[i] = $urandom();
        tbl[t].dr[i] = $urandom();
        tbl[t].el[i] = expect_sample(tbl[t].dl[i], wl_bits(tbl[t].wl));
        tbl[t].er[i] = expect_sample(tbl[t].dr[i], wl_bits(tbl[t].wl));
      end
      frames = tbl[t].n + 6;
      wd += frames * (tbl[t].fs + 1) * (tbl[t].div + 1);
    end
    wd_cycles = wd;
    wait (rst_n);
    foreach (tbl[t])
    begin
      err0 = errors;
      if (tbl[t].kind == K_REGS)
        run_regs(tbl[t]);
      else
        run_stream(tbl[t]);
      if (errors == err0)
        $display("%s: pass", tbl[t].name);
      else
      begin
        $display("%s: fail, %0d errors", tbl[t].name, errors - err0);
        fails++;
      end
    end
    $display("Tests passed %0d, failed %0d", 8 - fails, fails);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: testbench/codec_drvr_asserts.sv
// Concurrent checks on both handshakes and the frame sync pulses
// Bound to codec_drvr
`timescale 1ns/1ps

module codec_drvr_asserts (
  input logic        clk,
  input logic        rst_n,
  input logic        dac_req,
  input logic        dac_ack,
  input logic        adc_req,
  input logic        adc_ack,
  input logic [31:0] adc_left,
  input logic [31:0] adc_right,
  input logic        aud_bclk,
  input logic        aud_daclrck,
  input logic        aud_adclrck
);

  logic       bclk_d;
  logic       lrck_d;
  logic [3:0] rise_cnt;   // Bit clock rises seen while sync is high

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bclk_d   <= 1'b0;
      lrck_d   <= 1'b0;
      rise_cnt <= '0;
    end
    else
    begin
      bclk_d <= aud_bclk;
      lrck_d <= aud_daclrck;
      if (aud_daclrck && !lrck_d)
        rise_cnt <= (aud_bclk && !bclk_d) ? 4'd1 : 4'd0;
      else if (aud_daclrck && aud_bclk && !bclk_d && rise_cnt != 4'hF)
        rise_cnt <= rise_cnt + 4'd1;
    end
  end

  dac_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    dac_req && !dac_ack |=> dac_req)
    else $error("dac_req dropped before dac_ack");

  adc_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    adc_req && !adc_ack |=> adc_req)
    else $error("adc_req dropped before adc_ack");

  adc_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
    $past(adc_req) && adc_req |-> $stable(adc_left) && $stable(adc_right))
    else $error("ADC data changed while adc_req was high");

  sync_one_bit: assert property (@(posedge clk) disable iff (!rst_n)
    !aud_daclrck && lrck_d |-> rise_cnt == 4'd1)
    else $error("Frame sync pulse not one bit period long");

  // ADC sync must follow the same one-bit pulse
  adc_sync_match: assert property (@(posedge clk) disable iff (!rst_n)
    aud_adclrck == aud_daclrck)
    else $error("ADC frame sync differs from DAC frame sync");

endmodule

bind codec_drvr codec_drvr_asserts u_asserts (
  .clk, .rst_n, .dac_req, .dac_ack, .adc_req, .adc_ack,
  .adc_left, .adc_right, .aud_bclk, .aud_daclrck, .aud_adclrck
);

// File: testbench/tb_clk_gen.sv
// Testbench clock and reset generator
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;   // 100 ns period
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// File: source/codec_drvr.sv
// Codec driver top level: register block, frame timer and both serial paths
`timescale 1ns/1ps
`include "codec_params.svh"

module codec_drvr (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         lb_wr_en,
  input  logic                         lb_rd_en,
  input  logic [`CODEC_LB_ADDR_W-1:0]  lb_addr,
  input  logic [`CODEC_LB_DATA_W-1:0]  lb_wr_data,
  output logic                         lb_wr_valid,
  output logic                         lb_rd_valid,
  output logic [`CODEC_LB_DATA_W-1:0]  lb_rd_data,
  output logic                         dac_req,
  input  logic                         dac_ack,
  input  logic [31:0]                  dac_left,
  input  logic [31:0]                  dac_right,
  output logic                         adc_req,
  input  logic                         adc_ack,
  output logic [31:0]                  adc_left,
  output logic [31:0]                  adc_right,
  input  logic                         aud_adcdat,
  output logic                         aud_adclrck,
  output logic                         aud_bclk,
  output logic                         aud_dacdat,
  output logic                         aud_daclrck
);

  logic underrun;
  logic overrun;

  codec_cfg_if    cfg_if ();
  frame_timing_if tim_if ();

  codec_regs u_regs (
    .clk, .rst_n, .lb_wr_en, .lb_rd_en, .lb_addr, .lb_wr_data,
    .lb_wr_valid, .lb_rd_valid, .lb_rd_data,
    .cfg_if (cfg_if.regs), .tim_if (tim_if.monitor), .underrun, .overrun
  );

  frame_timer u_timer (.clk, .rst_n, .cfg_if (cfg_if.user), .tim_if (tim_if.source), .aud_bclk);

  dac_serializer u_dac (
    .clk, .rst_n, .cfg_if (cfg_if.user), .tim_if (tim_if.sink),
    .dac_req, .dac_ack, .dac_left, .dac_right, .aud_dacdat, .aud_daclrck, .underrun
  );

  adc_deserializer u_adc (
    .clk, .rst_n, .cfg_if (cfg_if.user), .tim_if (tim_if.sink),
    .aud_adcdat, .aud_adclrck, .adc_req, .adc_ack, .adc_left, .adc_right, .overrun
  );

endmodule

// File: codec_serial/adc_deserializer.sv
// ADC shift registers, sign extension and host handshake
`timescale 1ns/1ps

module adc_deserializer import codec_cfg_pkg::*, codec_pcm_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  codec_cfg_if.user    cfg_if,
  frame_timing_if.sink tim_if,
  input  logic         aud_adcdat,
  output logic         aud_adclrck,
  output logic         adc_req,
  input  logic         adc_ack,
  output logic [31:0]  adc_left,
  output logic [31:0]  adc_right,
  output logic         overrun
);

  pcm_pair_t rx_q;      // Shifted in MSB first
  logic      busy;      // Host still holds the previous pair
  logic      capture;

  assign busy    = adc_req || adc_ack;
  assign capture = tim_if.frame_end && cfg_if.cfg.adc_en;

  // Low W bits of the shift register to a signed 32-bit sample
  function automatic logic [31:0] sext(logic [31:0] x, word_len_t wl);
    case (wl)
      wl_16:   return {{16{x[15]}}, x[15:0]};
      wl_20:   return {{12{x[19]}}, x[19:0]};
      wl_24:   return {{8{x[23]}}, x[23:0]};
      default: return x;
    endcase
  endfunction

  always_ff @(posedge clk)
  begin
    if (tim_if.bclk_rise && tim_if.in_word)
    begin
      if (tim_if.chan == chan_left)
        rx_q.left <= {rx_q.left[30:0], aud_adcdat};
      else
        rx_q.right <= {rx_q.right[30:0], aud_adcdat};
    end
    if (capture && !busy)
    begin
      adc_left  <= sext(rx_q.left, cfg_if.cfg.word_len);
      adc_right <= sext(rx_q.right, cfg_if.cfg.word_len);
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      adc_req     <= 1'b0;
      overrun     <= 1'b0;
      aud_adclrck <= 1'b0;
    end
    else
    begin
      aud_adclrck <= tim_if.state == sync;
      overrun     <= capture && busy;   // New pair dropped
      if (capture && !busy)
        adc_req <= 1'b1;
      else if (adc_req && adc_ack)
        adc_req <= 1'b0;
    end
  end

endmodule

// File: codec_serial/dac_serializer.sv
// DAC holding buffer with host handshake and serial data output
`timescale 1ns/1ps

module dac_serializer import codec_cfg_pkg::*, codec_pcm_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  codec_cfg_if.user    cfg_if,
  frame_timing_if.sink tim_if,
  output logic         dac_req,
  input  logic         dac_ack,
  input  logic [31:0]  dac_left,
  input  logic [31:0]  dac_right,
  output logic         aud_dacdat,
  output logic         aud_daclrck,
  output logic         underrun
);

  pcm_pair_t  buf_q;        // Filled by the host
  pcm_pair_t  tx_q;         // Pair sent in the current frame
  logic       buf_full;
  logic       buf_full_nxt;
  logic       latch;
  logic       take;
  slot_t      pos;          // Bit position within the word
  logic [4:0] sel;
  logic       tx_bit;

  assign latch        = dac_req && dac_ack;
  assign take         = tim_if.frame_start && cfg_if.cfg.dac_en && buf_full;
  assign buf_full_nxt = latch || (buf_full && !take);

  assign pos    = (tim_if.chan == chan_left) ? tim_if.bit_idx - 1'b1
                : tim_if.bit_idx - word_bits(cfg_if.cfg.word_len) - 1'b1;
  assign sel    = 5'd31 - pos[4:0];   // MSB first
  assign tx_bit = (tim_if.chan == chan_left) ? tx_q.left[sel] : tx_q.right[sel];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      buf_full    <= 1'b0;
      dac_req     <= 1'b0;
      underrun    <= 1'b0;
      aud_dacdat  <= 1'b0;
      aud_daclrck <= 1'b0;
    end
    else
    begin
      buf_full    <= buf_full_nxt;
      dac_req     <= !buf_full_nxt && !dac_ack;   // Waits for ack low
      underrun    <= tim_if.frame_start && cfg_if.cfg.dac_en && !buf_full;
      aud_daclrck <= tim_if.state == sync;
      if (tim_if.bclk_fall)
        aud_dacdat <= tim_if.in_word && cfg_if.cfg.dac_en && tx_bit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (latch)
      buf_q <= '{left: dac_left, right: dac_right};
    if (tim_if.frame_start && cfg_if.cfg.dac_en)
      tx_q <= buf_full ? buf_q : '0;   // Zeros on underrun
  end

endmodule

// File: source/frame_timer.sv
// Bit-clock divider, slot counter and frame state machine
`timescale 1ns/1ps

module frame_timer import codec_cfg_pkg::*, codec_pcm_pkg::*; (
  input  logic           clk,
  input  logic           rst_n,
  codec_cfg_if.user      cfg_if,
  frame_timing_if.source tim_if,
  output logic           aud_bclk
);

  bclk_cnt_t    bclk_cntr;
  timer_state_t state_q;
  timer_state_t state_nxt;
  slot_t        bit_idx_q;
  slot_t        slot_w;
  logic         counting;
  logic         wrap;       // Last clock of a bit period
  logic         mid;        // Rising edge point
  logic         last_slot;

  assign slot_w    = word_bits(cfg_if.cfg.word_len);
  assign counting  = (state_q != idle) || cfg_if.run;
  assign wrap      = counting && (bclk_cntr == cfg_if.cfg.bclk_div);
  assign mid       = (state_q != idle) && (bclk_cntr == (cfg_if.cfg.bclk_div >> 1));
  assign last_slot = bit_idx_q >= cfg_if.cfg.fs_val;

  always_comb
  begin
    state_nxt = state_q;
    if (wrap)
    begin
      if (state_q != idle && last_slot)
        state_nxt = cfg_if.run ? sync : idle;   // Frame boundary
      else
      begin
        case (state_q)
          idle:    state_nxt = sync;
          sync:    state_nxt = left;
          left:    state_nxt = (bit_idx_q >= slot_w) ? right : left;
          right:   state_nxt = (bit_idx_q >= (slot_w << 1)) ? wait_fs : right;
          wait_fs: state_nxt = wait_fs;
          default: state_nxt = idle;
        endcase
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bclk_cntr          <= '0;
      state_q            <= idle;
      bit_idx_q          <= '0;
      aud_bclk           <= 1'b0;
      tim_if.bclk_rise   <= 1'b0;
      tim_if.bclk_fall   <= 1'b0;
      tim_if.frame_start <= 1'b0;
      tim_if.frame_end   <= 1'b0;
    end
    else
    begin
      bclk_cntr <= (!counting || wrap) ? '0 : bclk_cntr + 1'b1;
      if (wrap)
      begin
        state_q   <= state_nxt;
        bit_idx_q <= (state_nxt == sync || state_nxt == idle) ? '0 : bit_idx_q + 1'b1;
      end
      if (wrap)
        aud_bclk <= 1'b0;
      else if (mid)
        aud_bclk <= 1'b1;
      // Strobes line up with the registered bclk
      tim_if.bclk_rise   <= mid;
      tim_if.bclk_fall   <= wrap && (state_q != idle);
      tim_if.frame_start <= wrap && (state_nxt == sync);
      tim_if.frame_end   <= wrap && (state_q != idle) && last_slot;
    end
  end

  assign tim_if.bit_idx = bit_idx_q;
  assign tim_if.state   = state_q;
  assign tim_if.chan    = (state_q == right) ? chan_right : chan_left;
  assign tim_if.in_word = (state_q == left) || (state_q == right);

endmodule

// File: source/codec_regs.sv
// Local-bus register file, configuration check and xrun counters
`timescale 1ns/1ps
`include "codec_params.svh"

module codec_regs import codec_cfg_pkg::*; (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         lb_wr_en,
  input  logic                         lb_rd_en,
  input  logic [`CODEC_LB_ADDR_W-1:0]  lb_addr,
  input  logic [`CODEC_LB_DATA_W-1:0]  lb_wr_data,
  output logic                         lb_wr_valid,
  output logic                         lb_rd_valid,
  output logic [`CODEC_LB_DATA_W-1:0]  lb_rd_data,
  codec_cfg_if.regs                    cfg_if,
  frame_timing_if.monitor              tim_if,
  input  logic                         underrun,
  input  logic                         overrun
);

  typedef logic [`CODEC_LB_DATA_W-1:0] lb_data_t;

  codec_cfg_t cfg_q;
  logic       cfg_err;
  logic       xrun_rd;
  logic [7:0] underrun_cnt;
  logic [7:0] overrun_cnt;

  assign cfg_err = cfg_q.fs_val < (word_bits(cfg_q.word_len) << 1);   // Both words must fit
  assign xrun_rd = lb_rd_en && (lb_addr == `CODEC_XRUN_ADDR);

  assign cfg_if.cfg = cfg_q;
  assign cfg_if.run = (cfg_q.dac_en || cfg_q.adc_en) && !cfg_err;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cfg_q        <= '0;
      lb_wr_valid  <= 1'b0;
      lb_rd_valid  <= 1'b0;
      underrun_cnt <= '0;
      overrun_cnt  <= '0;
    end
    else
    begin
      lb_wr_valid <= lb_wr_en;
      lb_rd_valid <= lb_rd_en;
      if (lb_wr_en)
      begin
        case (lb_addr)
          `CODEC_CONFIG_ADDR:
          begin
            cfg_q.dac_en   <= lb_wr_data[0];
            cfg_q.adc_en   <= lb_wr_data[1];
            cfg_q.word_len <= word_len_t'(lb_wr_data[3:2]);
          end
          `CODEC_BCLK_DIV_ADDR: cfg_q.bclk_div <= lb_wr_data[`CODEC_BCLK_CNTR_W-1:0];
          `CODEC_FS_VAL_ADDR:   cfg_q.fs_val   <= lb_wr_data[`CODEC_FS_CNTR_W-1:0];
          default: ;
        endcase
      end
      // Read clears, an event in the same cycle still counts
      if (xrun_rd)
        underrun_cnt <= {7'd0, underrun};
      else if (underrun && underrun_cnt != 8'hFF)
        underrun_cnt <= underrun_cnt + 8'd1;
      if (xrun_rd)
        overrun_cnt <= {7'd0, overrun};
      else if (overrun && overrun_cnt != 8'hFF)
        overrun_cnt <= overrun_cnt + 8'd1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (lb_rd_en)
    begin
      case (lb_addr)
        `CODEC_CONFIG_ADDR:   lb_rd_data <= lb_data_t'({cfg_q.word_len, cfg_q.adc_en, cfg_q.dac_en});
        `CODEC_STATUS_ADDR:   lb_rd_data <= lb_data_t'({cfg_err, tim_if.state});
        `CODEC_BCLK_DIV_ADDR: lb_rd_data <= lb_data_t'(cfg_q.bclk_div);
        `CODEC_FS_VAL_ADDR:   lb_rd_data <= lb_data_t'(cfg_q.fs_val);
        `CODEC_XRUN_ADDR:     lb_rd_data <= lb_data_t'({overrun_cnt, underrun_cnt});
        default:              lb_rd_data <= `CODEC_BAD_ADDR_DATA;
      endcase
    end
  end

endmodule

// File: common/codec_ifs.sv
// codec_cfg_if: configuration and run flag from the register block
// frame_timing_if: per-slot strobes and frame position from the timer
`timescale 1ns/1ps

interface codec_cfg_if import codec_cfg_pkg::*; ();

  codec_cfg_t cfg;
  logic       run;   // Enabled and configuration valid

  modport regs (
    output cfg,
    output run
  );

  modport user (
    input  cfg,
    input  run
  );

endinterface

interface frame_timing_if import codec_cfg_pkg::*, codec_pcm_pkg::*; ();

  logic         bclk_rise;     // First cycle with bclk high
  logic         bclk_fall;     // First cycle of a new slot
  slot_t        bit_idx;
  pcm_chan_t    chan;
  logic         in_word;       // Slot carries sample data
  logic         frame_start;
  logic         frame_end;
  timer_state_t state;

  modport source (
    output bclk_rise, bclk_fall, bit_idx, chan, in_word,
    output frame_start, frame_end, state
  );

  modport sink (
    input  bclk_rise, bclk_fall, bit_idx, chan, in_word,
    input  frame_start, frame_end, state
  );

  modport monitor (
    input  state
  );

endinterface

// File: common/codec_pcm_pkg.sv
// Sample pair and channel types of the data paths

package codec_pcm_pkg;

  // One left/right sample pair, MSB aligned on the DAC side
  typedef struct packed {
    logic [31:0] left;
    logic [31:0] right;
  } pcm_pair_t;

  typedef enum logic {
    chan_left  = 1'b0,
    chan_right = 1'b1
  } pcm_chan_t;

endpackage

// File: common/codec_cfg_pkg.sv
// Configuration types: word length, timer state, register fields
// and the word length decode
`include "codec_params.svh"

package codec_cfg_pkg;

  typedef enum logic [1:0] {
    wl_16 = 2'd0,
    wl_20 = 2'd1,
    wl_24 = 2'd2,
    wl_32 = 2'd3
  } word_len_t;

  typedef enum logic [2:0] {idle, sync, left, right, wait_fs} timer_state_t;

  typedef logic [`CODEC_BCLK_CNTR_W-1:0] bclk_cnt_t;
  typedef logic [`CODEC_FS_CNTR_W-1:0]   slot_t;      // Bit slot within a frame

  typedef struct packed {
    logic      dac_en;
    logic      adc_en;
    word_len_t word_len;
    bclk_cnt_t bclk_div;   // Bit period is bclk_div+1 clocks
    slot_t     fs_val;     // Frame is fs_val+1 slots
  } codec_cfg_t;

  // Bits per channel word
  function automatic slot_t word_bits(word_len_t wl);
    case (wl)
      wl_16:   return slot_t'(16);
      wl_20:   return slot_t'(20);
      wl_24:   return slot_t'(24);
      default: return slot_t'(32);
    endcase
  endfunction

endpackage

// File: common/codec_params.svh
// Bus, counter widths and register map of the codec driver
`ifndef CODEC_PARAMS_SVH
`define CODEC_PARAMS_SVH

`define CODEC_LB_ADDR_W       8
`define CODEC_LB_DATA_W       32
`define CODEC_BCLK_CNTR_W     8
`define CODEC_FS_CNTR_W       16

`define CODEC_CONFIG_ADDR     8'h00
`define CODEC_STATUS_ADDR     8'h04
`define CODEC_BCLK_DIV_ADDR   8'h08
`define CODEC_FS_VAL_ADDR     8'h0C
`define CODEC_XRUN_ADDR       8'h10

`define CODEC_BAD_ADDR_DATA   32'hDEAD_BABE   // Unmapped read value

`endif
